// File: vcache_pkg.sv
// cache geometry, address field widths and word types
// opcode and execute state enums shared by the tile stages

package vcache_pkg;

  // word address and data widths
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int SRC_W  = 4;

  // direct-mapped geometry
  localparam int BLOCK_WORDS = 4;
  localparam int SETS        = 16;

  // address split, tag | index | offset
  localparam int OFFSET_W = $clog2(BLOCK_WORDS);
  localparam int INDEX_W  = $clog2(SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [SRC_W-1:0]    src_t;

  // network side opcodes
  typedef enum logic [2:0] {
    OP_LOAD     = 3'd0,
    OP_STORE    = 3'd1,
    OP_AMO_ADD  = 3'd2,
    OP_AMO_SWAP = 3'd3,
    OP_AMO_OR   = 3'd4
  } vcache_op_e;

  // execute stage FSM
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_LOOKUP     = 3'd1,
    ST_EVICT_REQ  = 3'd2,
    ST_EVICT_DATA = 3'd3,
    ST_FILL_REQ   = 3'd4,
    ST_FILL_DATA  = 3'd5,
    ST_RESP       = 3'd6
  } exec_state_e;

endpackage

// File: vcache_req_decode.sv
// request decode stage
// one-entry stage register holding opcode, address fields, data and source id

module vcache_req_decode (
  input  logic                   clk_i
  , input  logic                 rst_n_i

  // network request
  , input  logic                 req_v_i
  , output logic                 req_ready_o
  , input  vcache_pkg::vcache_op_e req_op_i
  , input  vcache_pkg::addr_t    req_addr_i
  , input  vcache_pkg::word_t    req_data_i
  , input  vcache_pkg::src_t     req_src_i

  // to execute
  , output logic                 dec_v_o
  , input  logic                 dec_ready_i
  , output vcache_pkg::vcache_op_e dec_op_o
  , output vcache_pkg::tag_t     dec_tag_o
  , output vcache_pkg::index_t   dec_index_o
  , output vcache_pkg::offset_t  dec_offset_o
  , output vcache_pkg::word_t    dec_data_o
  , output vcache_pkg::src_t     dec_src_o
);

  import vcache_pkg::*;

  logic       valid_r;
  logic       accept;

  vcache_op_e op_r;
  tag_t       tag_r;
  index_t     index_r;
  offset_t    offset_r;
  word_t      data_r;
  src_t       src_r;

  // open when empty or draining this cycle
  assign req_ready_o = ~valid_r | dec_ready_i;
  assign accept      = req_v_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_r <= 1'b0;
    end else if (accept) begin
      valid_r <= 1'b1;
    end else if (dec_ready_i) begin
      valid_r <= 1'b0;
    end
  end

  // address split happens on the way into the register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_r     <= req_op_i;
      tag_r    <= req_addr_i[ADDR_W-1 -: TAG_W];
      index_r  <= req_addr_i[OFFSET_W +: INDEX_W];
      offset_r <= req_addr_i[OFFSET_W-1:0];
      data_r   <= req_data_i;
      src_r    <= req_src_i;
    end
  end

  assign dec_v_o      = valid_r;
  assign dec_op_o     = op_r;
  assign dec_tag_o    = tag_r;
  assign dec_index_o  = index_r;
  assign dec_offset_o = offset_r;
  assign dec_data_o   = data_r;
  assign dec_src_o    = src_r;

endmodule

// File: vcache_exec.sv
// execute stage of the vcache tile
// tag, valid, dirty and data arrays, hit/miss FSM, atomic ALU, DMA evict and fill

module vcache_exec (
  input  logic                   clk_i
  , input  logic                 rst_n_i

  // from decode
  , input  logic                 dec_v_i
  , output logic                 dec_ready_o
  , input  vcache_pkg::vcache_op_e dec_op_i
  , input  vcache_pkg::tag_t     dec_tag_i
  , input  vcache_pkg::index_t   dec_index_i
  , input  vcache_pkg::offset_t  dec_offset_i
  , input  vcache_pkg::word_t    dec_data_i
  , input  vcache_pkg::src_t     dec_src_i

  // to result
  , output logic                 ex_v_o
  , input  logic                 ex_ready_i
  , output vcache_pkg::word_t    ex_data_o
  , output vcache_pkg::src_t     ex_src_o

  // dma request
  , output logic                 dma_req_v_o
  , output logic                 dma_req_we_o
  , output vcache_pkg::addr_t    dma_req_addr_o
  , input  logic                 dma_req_yumi_i

  // dma write data (evict)
  , output vcache_pkg::word_t    dma_wdata_o
  , output logic                 dma_wdata_v_o
  , input  logic                 dma_wdata_yumi_i

  // dma read data (fill)
  , input  vcache_pkg::word_t    dma_rdata_i
  , input  logic                 dma_rdata_v_i
  , output logic                 dma_rdata_ready_o
);

  import vcache_pkg::*;

  exec_state_e state_r;
  exec_state_e state_n;

  // request under service
  vcache_op_e  op_r;
  tag_t        tag_r;
  index_t      idx_r;
  offset_t     off_r;
  word_t       wdata_r;
  src_t        src_r;

  // cache storage
  tag_t        tag_mem  [SETS];
  word_t       data_mem [SETS*BLOCK_WORDS];
  logic [SETS-1:0] valid_r;
  logic [SETS-1:0] dirty_r;

  // word counter for evict and fill bursts
  offset_t     cnt_r;
  word_t       resp_data_r;

  logic        accept;
  logic        hit;
  logic        lookup_hit;
  logic        do_write;
  logic        last_word;
  logic        evict_fire;
  logic        fill_fire;
  word_t       old_word;
  word_t       new_word;
  word_t       resp_word;
  tag_t        dma_tag;

  assign dec_ready_o = (state_r == ST_IDLE);
  assign accept      = dec_v_i & dec_ready_o;

  assign hit        = valid_r[idx_r] && (tag_mem[idx_r] == tag_r);
  assign lookup_hit = (state_r == ST_LOOKUP) && hit;
  assign old_word   = data_mem[{idx_r, off_r}];
  assign last_word  = (cnt_r == offset_t'(BLOCK_WORDS-1));
  assign evict_fire = (state_r == ST_EVICT_DATA) && dma_wdata_yumi_i;
  assign fill_fire  = (state_r == ST_FILL_DATA) && dma_rdata_v_i;

  // atomic ALU; response is always the old word, except for a store
  always_comb begin
    new_word  = wdata_r;
    resp_word = old_word;
    do_write  = 1'b1;
    case (op_r)
      OP_LOAD:     do_write = 1'b0;
      OP_STORE:    resp_word = '0;
      OP_AMO_ADD:  new_word = old_word + wdata_r;
      OP_AMO_SWAP: new_word = wdata_r;
      OP_AMO_OR:   new_word = old_word | wdata_r;
      default:     do_write = 1'b0;
    endcase
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_IDLE: begin
        if (dec_v_i) state_n = ST_LOOKUP;
      end
      ST_LOOKUP: begin
        if (hit) begin
          state_n = ST_RESP;
        end else if (valid_r[idx_r] && dirty_r[idx_r]) begin
          state_n = ST_EVICT_REQ;
        end else begin
          state_n = ST_FILL_REQ;
        end
      end
      ST_EVICT_REQ: begin
        if (dma_req_yumi_i) state_n = ST_EVICT_DATA;
      end
      ST_EVICT_DATA: begin
        if (evict_fire && last_word) state_n = ST_FILL_REQ;
      end
      ST_FILL_REQ: begin
        if (dma_req_yumi_i) state_n = ST_FILL_DATA;
      end
      // replay the lookup once the line is in
      ST_FILL_DATA: begin
        if (fill_fire && last_word) state_n = ST_LOOKUP;
      end
      ST_RESP: begin
        if (ex_ready_i) state_n = ST_IDLE;
      end
      default: state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= ST_IDLE;
      cnt_r   <= '0;
      valid_r <= '0;
      dirty_r <= '0;
    end else begin
      state_r <= state_n;
      // block size is a power of two, so the counter wraps back to zero
      if (evict_fire || fill_fire) begin
        cnt_r <= cnt_r + 1'b1;
      end
      if (fill_fire && last_word) begin
        valid_r[idx_r] <= 1'b1;
        dirty_r[idx_r] <= 1'b0;
      end else if (lookup_hit && do_write) begin
        dirty_r[idx_r] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_r    <= dec_op_i;
      tag_r   <= dec_tag_i;
      idx_r   <= dec_index_i;
      off_r   <= dec_offset_i;
      wdata_r <= dec_data_i;
      src_r   <= dec_src_i;
    end
    if (lookup_hit) begin
      resp_data_r <= resp_word;
    end
    if (fill_fire) begin
      data_mem[{idx_r, cnt_r}] <= dma_rdata_i;
    end else if (lookup_hit && do_write) begin
      data_mem[{idx_r, off_r}] <= new_word;
    end
    if (fill_fire && last_word) begin
      tag_mem[idx_r] <= tag_r;
    end
  end

  // victim tag while evicting, requested tag while filling
  assign dma_tag = (state_r == ST_EVICT_REQ) ? tag_mem[idx_r] : tag_r;

  assign dma_req_v_o       = (state_r == ST_EVICT_REQ) || (state_r == ST_FILL_REQ);
  assign dma_req_we_o      = (state_r == ST_EVICT_REQ);
  assign dma_req_addr_o    = {dma_tag, idx_r, {OFFSET_W{1'b0}}};
  assign dma_wdata_o       = data_mem[{idx_r, cnt_r}];
  assign dma_wdata_v_o     = (state_r == ST_EVICT_DATA);
  assign dma_rdata_ready_o = (state_r == ST_FILL_DATA);

  assign ex_v_o    = (state_r == ST_RESP);
  assign ex_data_o = resp_data_r;
  assign ex_src_o  = src_r;

endmodule

// File: vcache_resp.sv
// result stage
// one-entry response buffer between execute and the network

module vcache_resp (
  input  logic                clk_i
  , input  logic              rst_n_i

  // from execute
  , input  logic              ex_v_i
  , output logic              ex_ready_o
  , input  vcache_pkg::word_t ex_data_i
  , input  vcache_pkg::src_t  ex_src_i

  // network response
  , output logic              resp_v_o
  , output vcache_pkg::word_t resp_data_o
  , output vcache_pkg::src_t  resp_src_o
  , input  logic              resp_yumi_i
);

  logic full_r;
  logic load;

  // can take a new word when empty or being emptied
  assign ex_ready_o = ~full_r | resp_yumi_i;
  assign load       = ex_v_i & ex_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_r <= 1'b0;
    end else if (load) begin
      full_r <= 1'b1;
    end else if (resp_yumi_i) begin
      full_r <= 1'b0;
    end
  end

  // payload only moves on a load, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (load) begin
      resp_data_o <= ex_data_i;
      resp_src_o  <= ex_src_i;
    end
  end

  assign resp_v_o = full_r;

endmodule

// File: vcache_tile.sv
// vcache tile top level
// request decode, cache execute and response stages wired in a row

module vcache_tile (
  input  logic                   clk_i
  , input  logic                 rst_n_i

  // network request
  , input  logic                 req_v_i
  , output logic                 req_ready_o
  , input  vcache_pkg::vcache_op_e req_op_i
  , input  vcache_pkg::addr_t    req_addr_i
  , input  vcache_pkg::word_t    req_data_i
  , input  vcache_pkg::src_t     req_src_i

  // network response
  , output logic                 resp_v_o
  , output vcache_pkg::word_t    resp_data_o
  , output vcache_pkg::src_t     resp_src_o
  , input  logic                 resp_yumi_i

  // dma to external memory
  , output logic                 dma_req_v_o
  , output logic                 dma_req_we_o
  , output vcache_pkg::addr_t    dma_req_addr_o
  , input  logic                 dma_req_yumi_i
  , output vcache_pkg::word_t    dma_wdata_o
  , output logic                 dma_wdata_v_o
  , input  logic                 dma_wdata_yumi_i
  , input  vcache_pkg::word_t    dma_rdata_i
  , input  logic                 dma_rdata_v_i
  , output logic                 dma_rdata_ready_o
);

  import vcache_pkg::*;

  // decode to execute
  logic       dec_v;
  logic       dec_ready;
  vcache_op_e dec_op;
  tag_t       dec_tag;
  index_t     dec_index;
  offset_t    dec_offset;
  word_t      dec_data;
  src_t       dec_src;

  // execute to result
  logic       ex_v;
  logic       ex_ready;
  word_t      ex_data;
  src_t       ex_src;

  vcache_req_decode dec_stage (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.req_v_i(req_v_i)
    ,.req_ready_o(req_ready_o)
    ,.req_op_i(req_op_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.req_src_i(req_src_i)
    ,.dec_v_o(dec_v)
    ,.dec_ready_i(dec_ready)
    ,.dec_op_o(dec_op)
    ,.dec_tag_o(dec_tag)
    ,.dec_index_o(dec_index)
    ,.dec_offset_o(dec_offset)
    ,.dec_data_o(dec_data)
    ,.dec_src_o(dec_src)
  );

  vcache_exec exec_stage (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.dec_v_i(dec_v)
    ,.dec_ready_o(dec_ready)
    ,.dec_op_i(dec_op)
    ,.dec_tag_i(dec_tag)
    ,.dec_index_i(dec_index)
    ,.dec_offset_i(dec_offset)
    ,.dec_data_i(dec_data)
    ,.dec_src_i(dec_src)
    ,.ex_v_o(ex_v)
    ,.ex_ready_i(ex_ready)
    ,.ex_data_o(ex_data)
    ,.ex_src_o(ex_src)
    ,.dma_req_v_o(dma_req_v_o)
    ,.dma_req_we_o(dma_req_we_o)
    ,.dma_req_addr_o(dma_req_addr_o)
    ,.dma_req_yumi_i(dma_req_yumi_i)
    ,.dma_wdata_o(dma_wdata_o)
    ,.dma_wdata_v_o(dma_wdata_v_o)
    ,.dma_wdata_yumi_i(dma_wdata_yumi_i)
    ,.dma_rdata_i(dma_rdata_i)
    ,.dma_rdata_v_i(dma_rdata_v_i)
    ,.dma_rdata_ready_o(dma_rdata_ready_o)
  );

  vcache_resp resp_stage (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.ex_v_i(ex_v)
    ,.ex_ready_o(ex_ready)
    ,.ex_data_i(ex_data)
    ,.ex_src_i(ex_src)
    ,.resp_v_o(resp_v_o)
    ,.resp_data_o(resp_data_o)
    ,.resp_src_o(resp_src_o)
    ,.resp_yumi_i(resp_yumi_i)
  );

endmodule

// File: vcache_mem_model.sv
// DMA memory model for the vcache tile testbench
// block reads and writes with a fixed latency and a random stall

module vcache_mem_model (
  input  logic                clk_i
  , input  logic              rst_n_i
  , input  logic              dma_req_v_i
  , input  logic              dma_req_we_i
  , input  vcache_pkg::addr_t dma_req_addr_i
  , output logic              dma_req_yumi_o
  , input  vcache_pkg::word_t dma_wdata_i
  , input  logic              dma_wdata_v_i
  , output logic              dma_wdata_yumi_o
  , output vcache_pkg::word_t dma_rdata_o
  , output logic              dma_rdata_v_o
  , input  logic              dma_rdata_ready_i
  , output int                timeouts_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import vcache_pkg::*;

  localparam int LATENCY    = 2;
  localparam int WAIT_LIMIT = 2000;
  localparam int MEM_WORDS  = 1 << ADDR_W;

  word_t mem [MEM_WORDS];

  task automatic random_stall();
    int n;
    n = $urandom % 3;
    repeat (n) @(negedge clk_i);
  endtask

  task automatic serve_burst();
    addr_t base;
    logic  we;
    int    w;
    int    cycles;
    base = dma_req_addr_i;
    we   = dma_req_we_i;
    repeat (LATENCY) @(negedge clk_i);
    random_stall();
    dma_req_yumi_o = 1'b1;
    @(negedge clk_i);
    dma_req_yumi_o = 1'b0;
    for (w = 0; w < BLOCK_WORDS; w++) begin
      random_stall();
      cycles = 0;
      if (we) begin
        while (!dma_wdata_v_i && cycles < WAIT_LIMIT) begin
          @(negedge clk_i);
          cycles++;
        end
        if (!dma_wdata_v_i) begin
          $display("memory model timed out waiting for evict data");
          timeouts_o++;
        end else begin
          mem[base + addr_t'(w)] = dma_wdata_i;
          dma_wdata_yumi_o = 1'b1;
          @(negedge clk_i);
          dma_wdata_yumi_o = 1'b0;
        end
      end else begin
        dma_rdata_o   = mem[base + addr_t'(w)];
        dma_rdata_v_o = 1'b1;
        while (!dma_rdata_ready_i && cycles < WAIT_LIMIT) begin
          @(negedge clk_i);
          cycles++;
        end
        if (!dma_rdata_ready_i) begin
          $display("memory model timed out waiting for fill ready");
          timeouts_o++;
        end else begin
          @(negedge clk_i);
        end
        dma_rdata_v_o = 1'b0;
      end
    end
  endtask

  initial begin
    int a;
    for (a = 0; a < MEM_WORDS; a++) begin
      mem[a] = 32'hA500_0000 + word_t'(a);
    end
    dma_req_yumi_o   = 1'b0;
    dma_wdata_yumi_o = 1'b0;
    dma_rdata_o      = '0;
    dma_rdata_v_o    = 1'b0;
    timeouts_o       = 0;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && dma_req_v_i) begin
        serve_burst();
      end
    end
  end

endmodule

// File: vcache_tb.sv
// vcache tile testbench top
// clock, reset, cases file reader, request driver and in-order response checker

module vcache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import vcache_pkg::*;

  localparam int TIMEOUT = 2000;

  logic       clk;
  logic       rst_n;
  logic       req_v;
  logic       req_ready;
  vcache_op_e req_op;
  addr_t      req_addr;
  word_t      req_data;
  src_t       req_src;
  logic       resp_v;
  word_t      resp_data;
  src_t       resp_src;
  logic       resp_yumi;
  logic       dma_req_v;
  logic       dma_req_we;
  addr_t      dma_req_addr;
  logic       dma_req_yumi;
  word_t      dma_wdata;
  logic       dma_wdata_v;
  logic       dma_wdata_yumi;
  word_t      dma_rdata;
  logic       dma_rdata_v;
  logic       dma_rdata_ready;

  int error_count;
  int timeout_count;
  int mem_timeouts;
  bit aborted;

  // one entry per line of the cases file
  string      case_name [$];
  vcache_op_e case_op   [$];
  addr_t      case_addr [$];
  word_t      case_data [$];
  word_t      case_exp  [$];

  always #20 clk = ~clk;

  vcache_tile vcache_tile_i (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.req_v_i(req_v)
    ,.req_ready_o(req_ready)
    ,.req_op_i(req_op)
    ,.req_addr_i(req_addr)
    ,.req_data_i(req_data)
    ,.req_src_i(req_src)
    ,.resp_v_o(resp_v)
    ,.resp_data_o(resp_data)
    ,.resp_src_o(resp_src)
    ,.resp_yumi_i(resp_yumi)
    ,.dma_req_v_o(dma_req_v)
    ,.dma_req_we_o(dma_req_we)
    ,.dma_req_addr_o(dma_req_addr)
    ,.dma_req_yumi_i(dma_req_yumi)
    ,.dma_wdata_o(dma_wdata)
    ,.dma_wdata_v_o(dma_wdata_v)
    ,.dma_wdata_yumi_i(dma_wdata_yumi)
    ,.dma_rdata_i(dma_rdata)
    ,.dma_rdata_v_i(dma_rdata_v)
    ,.dma_rdata_ready_o(dma_rdata_ready)
  );

  vcache_mem_model mem_model (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.dma_req_v_i(dma_req_v)
    ,.dma_req_we_i(dma_req_we)
    ,.dma_req_addr_i(dma_req_addr)
    ,.dma_req_yumi_o(dma_req_yumi)
    ,.dma_wdata_i(dma_wdata)
    ,.dma_wdata_v_i(dma_wdata_v)
    ,.dma_wdata_yumi_o(dma_wdata_yumi)
    ,.dma_rdata_o(dma_rdata)
    ,.dma_rdata_v_o(dma_rdata_v)
    ,.dma_rdata_ready_i(dma_rdata_ready)
    ,.timeouts_o(mem_timeouts)
  );

  task automatic check_data(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_src(input string name, input src_t exp, input src_t act);
    if (exp !== act) begin
      $display("ERR %s: expected src %h, actual src %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      error_count++;
    end
  endtask

  task automatic parse_op(input string s, output vcache_op_e op, output bit ok);
    ok = 1'b1;
    op = OP_LOAD;
    if (s == "load") op = OP_LOAD;
    else if (s == "store") op = OP_STORE;
    else if (s == "add") op = OP_AMO_ADD;
    else if (s == "swap") op = OP_AMO_SWAP;
    else if (s == "or") op = OP_AMO_OR;
    else ok = 1'b0;
  endtask

  task automatic load_cases();
    int         fd;
    int         n;
    string      line;
    string      name;
    string      op_name;
    addr_t      addr_v;
    word_t      data_v;
    word_t      exp_v;
    vcache_op_e op;
    bit         ok;
    fd = $fopen("vcache_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open vcache_cases.txt");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // '#' lines describe the columns
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h", name, op_name, addr_v, data_v, exp_v);
          if (n == 5) begin
            parse_op(op_name, op, ok);
            if (ok) begin
              case_name.push_back(name);
              case_op.push_back(op);
              case_addr.push_back(addr_v);
              case_data.push_back(data_v);
              case_exp.push_back(exp_v);
            end else begin
              $display("unknown operation %s in case %s", op_name, name);
              error_count++;
            end
          end else if (n > 0) begin
            $display("a line of vcache_cases.txt has %0d fields instead of 5", n);
            error_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // idle tile after reset
  task automatic check_idle();
    repeat (5) begin
      @(negedge clk);
      check_flag("idle_resp_v", 1'b0, resp_v);
      check_flag("idle_dma_req_v", 1'b0, dma_req_v);
      check_flag("idle_dma_wdata_v", 1'b0, dma_wdata_v);
      check_flag("idle_dma_rdata_ready", 1'b0, dma_rdata_ready);
      check_flag("idle_req_ready", 1'b1, req_ready);
    end
  endtask

  task automatic drive_requests();
    int k;
    int cycles;
    for (k = 0; k < case_name.size() && !aborted; k++) begin
      req_v    = 1'b1;
      req_op   = case_op[k];
      req_addr = case_addr[k];
      req_data = case_data[k];
      req_src  = src_t'(k % 16);
      cycles   = 0;
      while (!req_ready && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (!req_ready) begin
        $display("timed out waiting for the tile to accept request %s", case_name[k]);
        timeout_count++;
        aborted = 1'b1;
      end else begin
        // transfer on the rising edge after ready is seen
        @(negedge clk);
      end
    end
    req_v = 1'b0;
  endtask

  task automatic collect_responses();
    int k;
    int cycles;
    int hold;
    for (k = 0; k < case_name.size() && !aborted; k++) begin
      cycles = 0;
      while (!resp_v && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (!resp_v) begin
        $display("timed out waiting for the response to %s", case_name[k]);
        timeout_count++;
        aborted = 1'b1;
      end else begin
        // payload has to hold while yumi stays low
        if (case_name[k].substr(0, 2) == "bp_") begin
          hold = $urandom % 6;
          repeat (hold) begin
            @(negedge clk);
            check_flag({case_name[k], "_hold_v"}, 1'b1, resp_v);
            check_data({case_name[k], "_hold_data"}, case_exp[k], resp_data);
            check_src({case_name[k], "_hold_src"}, src_t'(k % 16), resp_src);
          end
        end
        check_data(case_name[k], case_exp[k], resp_data);
        check_src(case_name[k], src_t'(k % 16), resp_src);
        resp_yumi = 1'b1;
        @(negedge clk);
        resp_yumi = 1'b0;
      end
    end
  endtask

  initial begin
    void'($urandom(51));
    clk           = 1'b0;
    rst_n         = 1'b0;
    req_v         = 1'b0;
    req_op        = OP_LOAD;
    req_addr      = '0;
    req_data      = '0;
    req_src       = '0;
    resp_yumi     = 1'b0;
    error_count   = 0;
    timeout_count = 0;
    aborted       = 1'b0;
    load_cases();
    if (case_name.size() == 0) begin
      $display("no cases were read from vcache_cases.txt");
      error_count++;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_idle();
    fork
      drive_requests();
      collect_responses();
    join
    repeat (5) @(negedge clk);
    timeout_count = timeout_count + mem_timeouts;
    $display("cases: %0d  errors: %0d  timeouts: %0d", case_name.size(), error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: vcache_cases.txt
# columns: name op addr data expected (addr is a hex word address, data and expected in hex)
# op is one of load store add swap or; names starting with bp_ run under response back-pressure
cold_load      load  010 00000000 A5000010
same_blk_load  load  013 00000000 A5000013
st_word        store 021 12345678 00000000
ld_stored      load  021 00000000 12345678
amo_add_old    add   030 00000010 A5000030
amo_add_new    load  030 00000000 A5000040
amo_swap_old   swap  031 CAFEF00D A5000031
amo_swap_new   load  031 00000000 CAFEF00D
amo_or_old     or    032 0F0F0000 A5000032
amo_or_new     load  032 00000000 AF0F0032
ev_store       store 045 11112222 00000000
ev_conflict    load  085 00000000 A5000085
ev_reload      load  045 00000000 11112222
ev_amo_add     add   0C4 00000005 A50000C4
ev_dirty_amo   load  044 00000000 A5000044
ev_amo_back    load  0C4 00000000 A50000C9
bp_store_a     store 100 0000AAAA 00000000
bp_load_a      load  100 00000000 0000AAAA
bp_swap_c      swap  1F3 00000077 A50001F3
bp_load_c      load  1F3 00000000 00000077
bp_reload_amo  load  030 00000000 A5000040
bp_or_d        or    2A2 00000100 A50002A2
bp_load_d      load  2A2 00000000 A50003A2
bp_reload_st   load  021 00000000 12345678
bp_load_swap   load  031 00000000 CAFEF00D
bp_add_e       add   3FF FFFFFFFF A50003FF
bp_load_e      load  3FF 00000000 A50003FE

// File: filelist.f
vcache_pkg.sv
vcache_req_decode.sv
vcache_exec.sv
vcache_resp.sv
vcache_tile.sv
vcache_mem_model.sv
vcache_tb.sv

// File: Makefile
# Verilator build and run of the vcache tile testbench

VERILATOR ?= verilator
TOP       ?= vcache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it into $(LOG), search the log for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
